// File: source/cpuPkg.sv
package cpuPkg;

  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  typedef logic [31:0] instrT;
  typedef logic [4:0]  regIdxT;
  typedef logic [6:0]  opcodeT;

  localparam addrT resetPc = 32'h0000_0000;

  // major opcodes of the supported subset
  localparam opcodeT opReg    = 7'b0110011;
  localparam opcodeT opImm    = 7'b0010011;
  localparam opcodeT opLoad   = 7'b0000011;
  localparam opcodeT opStore  = 7'b0100011;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opJal    = 7'b1101111;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
  } aluOpT;

  typedef enum logic [1:0] {
    resultAlu, resultLoad, resultLink
  } resultSrcT;

  typedef struct packed {
    logic      regWrite;
    logic      memRead;
    logic      memWrite;
    logic      branch;
    logic      jump;
    logic      aluSrcImm;
    aluOpT     aluOp;
    resultSrcT resultSrc;
  } controlT;

  // fetch/decode register
  typedef struct packed {
    logic  valid;
    addrT  pc;
    instrT instr;
  } fetchToDecodeT;

  typedef struct packed {
    logic    valid;
    addrT    pc;
    controlT control;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    dataT    imm;
    dataT    rs1Data;
    dataT    rs2Data;
  } decodeToExecT;

  typedef struct packed {
    logic    valid;
    controlT control;
    regIdxT  rd;
    dataT    aluResult;
    dataT    storeData;
    addrT    linkAddr;
  } execToMemT;

  // one register write, also used for forwarding
  typedef struct packed {
    logic   valid;
    regIdxT rd;
    dataT   data;
  } retireT;

endpackage

// File: source/busPkg.sv
package busPkg;

  // wishbone classic, 32 bit words only
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] datO;
  } wbMasterT;

  typedef struct packed {
    logic [31:0] datI;
    logic        ack;
  } wbSlaveT;

endpackage

// File: source/fetchStage.sv
module fetchStage import cpuPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall,
  input  logic          flush,
  input  logic          redirect,
  input  addrT          redirectPc,
  output addrT          imemAddr,
  input  instrT         imemData,
  output fetchToDecodeT fetchOut
);

  addrT pc;
  addrT nextPc;

  // a redirect from execute wins over the sequential pc
  assign nextPc = redirect ? redirectPc : pc + 32'd4;

  assign imemAddr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= resetPc;
    end else if (!stall) begin
      pc <= nextPc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchOut.valid <= 1'b0;
    end else if (flush) begin
      fetchOut.valid <= 1'b0;
    end else if (!stall) begin
      fetchOut.valid <= 1'b1;
      fetchOut.pc    <= pc;
      fetchOut.instr <= imemData;
    end
  end

endmodule

// File: source/controlDecoder.sv
module controlDecoder import cpuPkg::*; (
  input  instrT   instr,
  output controlT control,
  output dataT    imm
);

  opcodeT     opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  aluOpT      fieldOp;
  logic       fieldOk;
  dataT       immI;
  dataT       immS;
  dataT       immB;
  dataT       immJ;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // alu function shared by the register and immediate forms
  always_comb begin
    fieldOk = 1'b1;
    case (funct3)
      3'b000:  fieldOp = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
      3'b010:  fieldOp = aluSlt;
      3'b100:  fieldOp = aluXor;
      3'b110:  fieldOp = aluOr;
      3'b111:  fieldOp = aluAnd;
      default: begin
        fieldOp = aluAdd;
        fieldOk = 1'b0;
      end
    endcase
  end

  // anything unsupported falls out as a harmless bubble
  always_comb begin
    control = '0;
    imm     = '0;
    case (opcode)
      opReg: begin
        control.regWrite = fieldOk;
        control.aluOp    = fieldOp;
      end
      opImm: begin
        control.regWrite  = fieldOk;
        control.aluSrcImm = 1'b1;
        control.aluOp     = fieldOp;
        imm               = immI;
      end
      opLoad: begin
        control.regWrite  = (funct3 == 3'b010);
        control.memRead   = (funct3 == 3'b010);
        control.aluSrcImm = 1'b1;
        control.resultSrc = resultLoad;
        imm               = immI;
      end
      opStore: begin
        control.memWrite  = (funct3 == 3'b010);
        control.aluSrcImm = 1'b1;
        imm               = immS;
      end
      opBranch: begin
        // only beq
        control.branch = (funct3 == 3'b000);
        control.aluOp  = aluSub;
        imm            = immB;
      end
      opJal: begin
        control.regWrite  = 1'b1;
        control.jump      = 1'b1;
        control.aluSrcImm = 1'b1;
        control.aluOp     = aluPassB;
        control.resultSrc = resultLink;
        imm               = immJ;
      end
      default: begin
        control = '0;
      end
    endcase
  end

endmodule

// File: source/registerFile.sv
module registerFile import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  regIdxT rs1,
  input  regIdxT rs2,
  output dataT   rd1,
  output dataT   rd2,
  input  retireT wr
);

  // x0 has no storage
  dataT regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // write-first: a same-cycle write is visible on the read ports
  always_comb begin
    if (rs1 == '0) begin
      rd1 = '0;
    end else if (wr.valid && wr.rd == rs1) begin
      rd1 = wr.data;
    end else begin
      rd1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rd2 = '0;
    end else if (wr.valid && wr.rd == rs2) begin
      rd2 = wr.data;
    end else begin
      rd2 = regs[rs2];
    end
  end

endmodule

// File: source/executeStage.sv
module executeStage import cpuPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         stall,
  input  logic         flush,
  input  decodeToExecT decodeIn,
  input  retireT       fwd,
  output execToMemT    memOut,
  output logic         redirect,
  output addrT         redirectPc
);

  decodeToExecT execReg;
  dataT         srcA;
  dataT         srcB;
  dataT         aluB;
  dataT         aluResult;
  logic         fwdA;
  logic         fwdB;
  logic         operandsEqual;

  // decode/execute register
  always_ff @(posedge clk) begin
    if (reset) begin
      execReg.valid <= 1'b0;
    end else if (flush) begin
      execReg.valid <= 1'b0;
    end else if (!stall) begin
      execReg <= decodeIn;
    end
  end

  // bypass from memory/writeback, x0 never forwards
  assign fwdA = fwd.valid && fwd.rd == execReg.rs1 && execReg.rs1 != '0;
  assign fwdB = fwd.valid && fwd.rd == execReg.rs2 && execReg.rs2 != '0;

  assign srcA = fwdA ? fwd.data : execReg.rs1Data;
  assign srcB = fwdB ? fwd.data : execReg.rs2Data;
  assign aluB = execReg.control.aluSrcImm ? execReg.imm : srcB;

  always_comb begin
    case (execReg.control.aluOp)
      aluAdd:   aluResult = srcA + aluB;
      aluSub:   aluResult = srcA - aluB;
      aluAnd:   aluResult = srcA & aluB;
      aluOr:    aluResult = srcA | aluB;
      aluXor:   aluResult = srcA ^ aluB;
      aluSlt:   aluResult = {31'b0, $signed(srcA) < $signed(aluB)};
      aluPassB: aluResult = aluB;
      default:  aluResult = srcA + aluB;
    endcase
  end

  // branch resolution, beq compares the two register operands
  assign operandsEqual = (srcA == srcB);
  assign redirect = execReg.valid &&
                    (execReg.control.jump || (execReg.control.branch && operandsEqual));
  assign redirectPc = execReg.pc + execReg.imm;

  // execute/memory register
  always_ff @(posedge clk) begin
    if (reset) begin
      memOut.valid <= 1'b0;
    end else if (!stall) begin
      memOut.valid     <= execReg.valid;
      memOut.control   <= execReg.control;
      memOut.rd        <= execReg.rd;
      memOut.aluResult <= aluResult;
      memOut.storeData <= srcB;
      memOut.linkAddr  <= execReg.pc + 32'd4;
    end
  end

endmodule

// File: source/memoryStage.sv
module memoryStage import cpuPkg::*, busPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  execToMemT memIn,
  output wbMasterT  wbOut,
  input  wbSlaveT   wbIn,
  output logic      busBusy,
  output retireT    fwd,
  output retireT    retire
);

  typedef enum logic {stateIdle, stateAccess} busStateT;

  busStateT state;
  logic     memOp;
  logic     accessDone;
  logic     writeOk;
  dataT     wbData;

  assign memOp      = memIn.valid && (memIn.control.memRead || memIn.control.memWrite);
  assign accessDone = (state == stateAccess) && wbIn.ack;

  // the pipeline holds until the slave acks, and moves on in the ack cycle
  assign busBusy = memOp && !accessDone;

  // bus outputs are registered so adr, we and datO stay put while waiting
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= stateIdle;
      wbOut.cyc <= 1'b0;
      wbOut.stb <= 1'b0;
    end else begin
      case (state)
        stateIdle: begin
          if (memOp) begin
            state      <= stateAccess;
            wbOut.cyc  <= 1'b1;
            wbOut.stb  <= 1'b1;
            wbOut.we   <= memIn.control.memWrite;
            wbOut.adr  <= memIn.aluResult;
            wbOut.datO <= memIn.storeData;
          end
        end
        stateAccess: begin
          if (wbIn.ack) begin
            state     <= stateIdle;
            wbOut.cyc <= 1'b0;
            wbOut.stb <= 1'b0;
          end
        end
        default: state <= stateIdle;
      endcase
    end
  end

  always_comb begin
    case (memIn.control.resultSrc)
      resultLoad: wbData = wbIn.datI;
      resultLink: wbData = memIn.linkAddr;
      default:    wbData = memIn.aluResult;
    endcase
  end

  // loads write back only in their ack cycle
  assign writeOk = memIn.valid && memIn.control.regWrite && memIn.rd != '0 &&
                   (!memIn.control.memRead || accessDone);

  always_comb begin
    retire.valid = writeOk;
    retire.rd    = memIn.rd;
    retire.data  = wbData;
  end

  assign fwd = retire;

endmodule

// File: source/hazardUnit.sv
module hazardUnit (
  input  logic busBusy,
  input  logic redirect,
  output logic stall,
  output logic flushDecode,
  output logic flushExec
);

  logic takeRedirect;

  // fetch, decode and execute all hold while a bus transfer is open
  assign stall = busBusy;

  // a redirect seen during a stall may rest on a load that has not returned,
  // so it only acts once the stall is gone
  assign takeRedirect = redirect && !stall;

  // both younger instructions are on the wrong path
  assign flushDecode = takeRedirect;
  assign flushExec   = takeRedirect;

endmodule

// File: source/cpuTop.sv
module cpuTop import cpuPkg::*, busPkg::*; (
  input  logic     clk,
  input  logic     reset,
  output addrT     imemAddr,
  input  instrT    imemData,
  output wbMasterT wbOut,
  input  wbSlaveT  wbIn,
  output retireT   retire
);

  fetchToDecodeT fetchOut;
  controlT       control;
  dataT          imm;
  dataT          rd1;
  dataT          rd2;
  decodeToExecT  decodeIn;
  execToMemT     memOut;
  retireT        fwd;
  logic          redirect;
  addrT          redirectPc;
  logic          busBusy;
  logic          stall;
  logic          flushDecode;
  logic          flushExec;

  fetchStage fetchStage_i (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flushDecode),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .fetchOut   (fetchOut)
  );

  controlDecoder controlDecoder_i (
    .instr   (fetchOut.instr),
    .control (control),
    .imm     (imm)
  );

  registerFile registerFile_i (
    .clk   (clk),
    .reset (reset),
    .rs1   (fetchOut.instr[19:15]),
    .rs2   (fetchOut.instr[24:20]),
    .rd1   (rd1),
    .rd2   (rd2),
    .wr    (fwd)
  );

  // decoder and register file results meet here
  always_comb begin
    decodeIn.valid   = fetchOut.valid;
    decodeIn.pc      = fetchOut.pc;
    decodeIn.control = control;
    decodeIn.rs1     = fetchOut.instr[19:15];
    decodeIn.rs2     = fetchOut.instr[24:20];
    decodeIn.rd      = fetchOut.instr[11:7];
    decodeIn.imm     = imm;
    decodeIn.rs1Data = rd1;
    decodeIn.rs2Data = rd2;
  end

  executeStage executeStage_i (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flushExec),
    .decodeIn   (decodeIn),
    .fwd        (fwd),
    .memOut     (memOut),
    .redirect   (redirect),
    .redirectPc (redirectPc)
  );

  memoryStage memoryStage_i (
    .clk     (clk),
    .reset   (reset),
    .memIn   (memOut),
    .wbOut   (wbOut),
    .wbIn    (wbIn),
    .busBusy (busBusy),
    .fwd     (fwd),
    .retire  (retire)
  );

  hazardUnit hazardUnit_i (
    .busBusy     (busBusy),
    .redirect    (redirect),
    .stall       (stall),
    .flushDecode (flushDecode),
    .flushExec   (flushExec)
  );

endmodule

// File: test/cpuTop_chk.sv
module cpuTopChk import cpuPkg::*, busPkg::*; (
  input logic     clk,
  input logic     reset,
  input wbMasterT wbOut,
  input wbSlaveT  wbIn,
  input retireT   retire
);

  // request fields hold while the slave keeps ack low
  busHold: assert property (@(posedge clk) disable iff (reset)
    (wbOut.stb && !wbIn.ack) |=> $stable(wbOut.adr) && $stable(wbOut.we) && $stable(wbOut.datO))
    else $error("wishbone request changed before ack");

  stbNeedsCyc: assert property (@(posedge clk) disable iff (reset)
    wbOut.stb |-> wbOut.cyc)
    else $error("stb high without cyc");

  dropAfterAck: assert property (@(posedge clk) disable iff (reset)
    (wbOut.cyc && wbIn.ack) |=> !wbOut.cyc)
    else $error("cyc still high one cycle after ack");

  // skip the first edge, the flops are not yet reset there
  resetQuiet: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!wbOut.cyc && !retire.valid))
    else $error("bus or retire active during reset");

endmodule

// File: test/cpuTb.sv
module cpuTb import cpuPkg::*, busPkg::*; ();

  localparam int numInstr = 200;
  localparam int timeoutCycles = numInstr * 8;
  localparam addrT dataBase = 32'h0000_0400;
  localparam addrT loopPc = addrT'((numInstr - 1) * 4);
  localparam instrT nopInstr = 32'h0000_0013;

  // instruction kinds used by the generator and the ISA model
  localparam int kindReg = 0;
  localparam int kindImm = 1;
  localparam int kindLoad = 2;
  localparam int kindStore = 3;
  localparam int kindBeq = 4;
  localparam int kindJal = 5;

  logic     clk = 1'b0;
  logic     reset;
  addrT     imemAddr;
  instrT    imemData;
  wbMasterT wbOut;
  wbSlaveT  wbIn = '0;
  retireT   retire;

  integer seed = 84596;

  instrT      prog [0:255];
  int         kindOf [0:255];
  logic [2:0] f3Of [0:255];
  logic       subOf [0:255];
  regIdxT     rdOf [0:255];
  regIdxT     rs1Of [0:255];
  regIdxT     rs2Of [0:255];
  dataT       immOf [0:255];
  dataT       slaveMem [0:63];
  dataT       modelMem [0:63];
  dataT       modelRegs [0:31];
  int         waitPlan [0:255];

  retireT   retireQ [$];
  wbMasterT busQ [$];
  retireT   expRet;
  wbMasterT expBus;

  int     transferCount = 0;
  int     waitLeft = 0;
  logic   inTransfer = 1'b0;
  logic   slaveWe;
  addrT   slaveIdx;
  logic   loopSeen = 1'b0;
  logic   prevReset = 1'b1;
  addrT   prevAddr = '0;
  int     cycleCount = 0;

  always #2 clk = ~clk;

  cpuTop u_dut (
    .clk      (clk),
    .reset    (reset),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbOut    (wbOut),
    .wbIn     (wbIn),
    .retire   (retire)
  );

  bind cpuTop cpuTopChk cpuTopChk_i (
    .clk    (clk),
    .reset  (reset),
    .wbOut  (wbOut),
    .wbIn   (wbIn),
    .retire (retire)
  );

  // combinational instruction ROM with nops past the program
  assign imemData = (imemAddr < 32'd1024) ? prog[imemAddr[9:2]] : nopInstr;

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail %s: got %h expected %h", name, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic instrT encR(input logic sub, input logic [2:0] f3, input regIdxT rd,
                                 input regIdxT rs1, input regIdxT rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic instrT encI(input logic [6:0] op, input logic [2:0] f3, input regIdxT rd,
                                 input regIdxT rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instrT encS(input regIdxT rs1, input regIdxT rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic instrT encB(input regIdxT rs1, input regIdxT rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic instrT encJ(input regIdxT rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  // reference ALU with funct3 meaning from the ISA
  function automatic dataT modelAlu(input logic [2:0] f3, input logic sub, input dataT a,
                                    input dataT b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic generateProgram();
    int r;
    int d;
    int w;
    logic [11:0] imm12;
    for (int i = 0; i < 256; i++) begin
      prog[i] = nopInstr;
      waitPlan[i] = pick(4);
    end
    for (int i = 0; i < numInstr - 1; i++) begin
      r = pick(100);
      rdOf[i] = 5'(pick(8));
      rs1Of[i] = 5'(pick(8));
      rs2Of[i] = 5'(pick(8));
      f3Of[i] = 3'b000;
      subOf[i] = 1'b0;
      // forward targets only and never past the final loop
      d = 2 + pick(4);
      if (i + d > numInstr - 1) begin
        d = numInstr - 1 - i;
      end
      if (r < 30) begin
        kindOf[i] = kindReg;
        case (pick(5))
          0: f3Of[i] = 3'b000;
          1: f3Of[i] = 3'b010;
          2: f3Of[i] = 3'b100;
          3: f3Of[i] = 3'b110;
          default: f3Of[i] = 3'b111;
        endcase
        subOf[i] = (f3Of[i] == 3'b000) && pick(2) == 1;
        prog[i] = encR(subOf[i], f3Of[i], rdOf[i], rs1Of[i], rs2Of[i]);
      end else if (r < 55) begin
        kindOf[i] = kindImm;
        case (pick(5))
          0, 1: f3Of[i] = 3'b000;
          2: f3Of[i] = 3'b010;
          3: f3Of[i] = 3'b100;
          default: f3Of[i] = (pick(2) == 1) ? 3'b110 : 3'b111;
        endcase
        imm12 = 12'($random(seed));
        immOf[i] = {{20{imm12[11]}}, imm12};
        prog[i] = encI(opImm, f3Of[i], rdOf[i], rs1Of[i], imm12);
      end else if (r < 80) begin
        // word accesses off x0 into the data region
        w = pick(64);
        rs1Of[i] = 5'd0;
        immOf[i] = dataBase + 32'(w * 4);
        if (r < 68) begin
          kindOf[i] = kindLoad;
          prog[i] = encI(opLoad, 3'b010, rdOf[i], 5'd0, immOf[i][11:0]);
        end else begin
          kindOf[i] = kindStore;
          prog[i] = encS(5'd0, rs2Of[i], immOf[i][11:0]);
        end
      end else if (r < 90) begin
        kindOf[i] = kindBeq;
        rs1Of[i] = 5'(pick(4));
        rs2Of[i] = 5'(pick(4));
        immOf[i] = 32'(d * 4);
        prog[i] = encB(rs1Of[i], rs2Of[i], 13'(d * 4));
      end else begin
        kindOf[i] = kindJal;
        immOf[i] = 32'(d * 4);
        prog[i] = encJ(rdOf[i], 21'(d * 4));
      end
    end
    // jal x0,0 as the final self-loop
    prog[numInstr - 1] = encJ(5'd0, 21'd0);
    for (int j = 0; j < 64; j++) begin
      slaveMem[j] = $random(seed);
      modelMem[j] = slaveMem[j];
    end
  endtask

  task automatic writeReg(input regIdxT rd, input dataT value);
    retireT ev;
    if (rd != 5'd0) begin
      modelRegs[rd] = value;
      ev.valid = 1'b1;
      ev.rd = rd;
      ev.data = value;
      retireQ.push_back(ev);
    end
  endtask

  // in-order ISA model that fills the expected retire and bus queues
  task automatic runModel();
    int idx;
    dataT a;
    dataT b;
    addrT adr;
    wbMasterT acc;
    idx = 0;
    for (int j = 0; j < 32; j++) begin
      modelRegs[j] = '0;
    end
    while (idx != numInstr - 1) begin
      a = modelRegs[rs1Of[idx]];
      b = modelRegs[rs2Of[idx]];
      adr = a + immOf[idx];
      acc = '0;
      case (kindOf[idx])
        kindReg: writeReg(rdOf[idx], modelAlu(f3Of[idx], subOf[idx], a, b));
        kindImm: writeReg(rdOf[idx], modelAlu(f3Of[idx], 1'b0, a, immOf[idx]));
        kindLoad: begin
          acc.adr = adr;
          busQ.push_back(acc);
          writeReg(rdOf[idx], modelMem[adr[7:2]]);
        end
        kindStore: begin
          acc.we = 1'b1;
          acc.adr = adr;
          acc.datO = b;
          busQ.push_back(acc);
          modelMem[adr[7:2]] = b;
        end
        kindJal: writeReg(rdOf[idx], 32'(idx * 4 + 4));
        default: ;
      endcase
      if (kindOf[idx] == kindJal || (kindOf[idx] == kindBeq && a == b)) begin
        idx = idx + int'(immOf[idx] / 4);
      end else begin
        idx = idx + 1;
      end
    end
  endtask

  // Wishbone slave with planned wait states
  always @(posedge clk) begin
    if (reset) begin
      inTransfer = 1'b0;
      #1 wbIn = '0;
    end else if (wbIn.ack) begin
      inTransfer = 1'b0;
      #1 wbIn.ack = 1'b0;
      wbIn.datI = 32'hDEAD_BEEF;
    end else if (wbOut.cyc && wbOut.stb) begin
      if (!inTransfer) begin
        inTransfer = 1'b1;
        if (busQ.size() == 0) begin
          reportFailure("a bus transfer started that the program does not make");
        end else begin
          expBus = busQ.pop_front();
          checkValue("wbOut.adr", wbOut.adr, expBus.adr);
          checkValue("wbOut.we", 32'(wbOut.we), 32'(expBus.we));
          if (expBus.we) begin
            checkValue("wbOut.datO", wbOut.datO, expBus.datO);
          end
          waitLeft = waitPlan[transferCount[7:0]];
          transferCount = transferCount + 1;
        end
      end
      if (waitLeft == 0) begin
        slaveWe = wbOut.we;
        slaveIdx = (wbOut.adr - dataBase) >> 2;
        if (slaveWe) begin
          slaveMem[slaveIdx[5:0]] = wbOut.datO;
        end
        #1 wbIn.ack = 1'b1;
        wbIn.datI = slaveWe ? 32'hDEAD_BEEF : slaveMem[slaveIdx[5:0]];
      end else begin
        waitLeft = waitLeft - 1;
      end
    end
  end

  // reset state, retire order and detection of the final loop
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (reset) begin
      if (cycleCount > 2) begin
        checkValue("wbOut.cyc", 32'(wbOut.cyc), 32'h0);
        checkValue("retire.valid", 32'(retire.valid), 32'h0);
        checkValue("imemAddr", imemAddr, resetPc);
      end
    end else begin
      if (prevReset) begin
        checkValue("imemAddr", imemAddr, resetPc);
        checkValue("wbOut.cyc", 32'(wbOut.cyc), 32'h0);
        checkValue("retire.valid", 32'(retire.valid), 32'h0);
      end
      if (retire.valid) begin
        if (retireQ.size() == 0) begin
          reportFailure("a register write retired that the program does not make");
        end else begin
          expRet = retireQ.pop_front();
          checkValue("retire.rd", 32'(retire.rd), 32'(expRet.rd));
          checkValue("retire.data", retire.data, expRet.data);
        end
      end
      // only the self-loop jumps backwards onto its own pc
      if (imemAddr == loopPc && prevAddr > loopPc) begin
        loopSeen = 1'b1;
      end
    end
    prevAddr = imemAddr;
    prevReset = reset;
  end

  initial begin
    #((16 + timeoutCycles) * 4);
    reportFailure("timeout, the program never reached its final loop");
  end

  initial begin
    reset = 1'b1;
    generateProgram();
    runModel();
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    wait (loopSeen);
    repeat (8) @(posedge clk);
    if (retireQ.size() == 0 && busQ.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      reportFailure("expected retire or bus events were left at the final loop");
    end
  end

endmodule

// File: sim.f
source/cpuPkg.sv
source/busPkg.sv
source/fetchStage.sv
source/controlDecoder.sv
source/registerFile.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/cpuTop.sv
test/cpuTop_chk.sv
test/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cpuTb -o cpuSim

status=0
./obj_dir/cpuSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0
